//--- design/riscv_isa_pkg.sv
package riscv_isa_pkg;

    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;

    // major opcodes in instr[6:0]
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // branch conditions
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // arithmetic funct3 shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        PASS_B
    } alu_op_e;

endpackage

//--- design/pipe_pkg.sv
package pipe_pkg;

    import riscv_isa_pkg::*;

    typedef enum logic {
        SRC1_RS1,
        SRC1_PC
    } src1_sel_e;

    typedef enum logic {
        SRC2_RS2,
        SRC2_IMM
    } src2_sel_e;

    // decode to execute
    typedef struct packed {
        logic [XLEN-1:0]      pc;
        logic [XLEN-1:0]      imm;
        logic [XLEN-1:0]      rs1_val;
        logic [XLEN-1:0]      rs2_val;
        logic [REG_IDX_W-1:0] rs1_idx;
        logic [REG_IDX_W-1:0] rs2_idx;
        logic [REG_IDX_W-1:0] rd;
        alu_op_e              alu_op;
        src1_sel_e            src1_sel;
        src2_sel_e            src2_sel;
        logic [2:0]           funct3;
        logic                 is_branch;
        logic                 is_jal;
        logic                 is_jalr;
        logic                 wben;
    } id_ex_t;

    // completed result and forwarding source
    typedef struct packed {
        logic [XLEN-1:0]      pc;
        logic [REG_IDX_W-1:0] rd;
        logic [XLEN-1:0]      data;
        logic                 wben;
    } ex_res_t;

endpackage

//--- design/id_stage.sv
`timescale 1ns/1ps

module id_stage import riscv_isa_pkg::*, pipe_pkg::*; (
    input  logic                 instr_valid_i,
    input  logic [31:0]          instr_i,
    input  logic [XLEN-1:0]      instr_pc_i,
    input  logic                 kill_i,
    output logic [REG_IDX_W-1:0] rs1_idx_o,
    output logic [REG_IDX_W-1:0] rs2_idx_o,
    input  logic [XLEN-1:0]      rs1_val_i,
    input  logic [XLEN-1:0]      rs2_val_i,
    output logic                 dec_valid_o,
    output id_ex_t               dec_o
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    alu_op_e         arith_op;

    assign opcode    = instr_i[6:0];
    assign funct3    = instr_i[14:12];
    assign rs1_idx_o = instr_i[19:15];
    assign rs2_idx_o = instr_i[24:20];

    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};

    // bit 30 picks SUB only for register ops, SRA/SRAI for both
    always_comb begin
        unique case (funct3)
            F3_ADD:  arith_op = (opcode == OPC_OP && instr_i[30]) ? SUB : ADD;
            F3_SLL:  arith_op = SLL;
            F3_SLT:  arith_op = SLT;
            F3_SLTU: arith_op = SLTU;
            F3_XOR:  arith_op = XOR;
            F3_SR:   arith_op = instr_i[30] ? SRA : SRL;
            F3_OR:   arith_op = OR;
            default: arith_op = AND;
        endcase
    end

    always_comb begin
        dec_o         = '0;
        dec_o.pc      = instr_pc_i;
        dec_o.rs1_val = rs1_val_i;
        dec_o.rs2_val = rs2_val_i;
        dec_o.rs1_idx = rs1_idx_o;
        dec_o.rs2_idx = rs2_idx_o;
        dec_o.rd      = instr_i[11:7];
        dec_o.funct3  = funct3;
        dec_o.alu_op  = ADD;

        unique case (opcode)
            OPC_OP: begin
                dec_o.alu_op = arith_op;
                dec_o.wben   = 1'b1;
            end
            OPC_OP_IMM: begin
                dec_o.alu_op   = arith_op;
                dec_o.src2_sel = SRC2_IMM;
                dec_o.imm      = imm_i;
                dec_o.wben     = 1'b1;
            end
            OPC_LUI: begin
                dec_o.alu_op   = PASS_B;
                dec_o.src2_sel = SRC2_IMM;
                dec_o.imm      = imm_u;
                dec_o.wben     = 1'b1;
            end
            OPC_AUIPC: begin
                dec_o.src1_sel = SRC1_PC;
                dec_o.src2_sel = SRC2_IMM;
                dec_o.imm      = imm_u;
                dec_o.wben     = 1'b1;
            end
            OPC_JAL: begin
                dec_o.imm    = imm_j;
                dec_o.is_jal = 1'b1;
                dec_o.wben   = 1'b1;
            end
            OPC_JALR: begin
                dec_o.imm     = imm_i;
                dec_o.is_jalr = 1'b1;
                dec_o.wben    = 1'b1;
            end
            OPC_BRANCH: begin
                dec_o.imm       = imm_b;
                dec_o.is_branch = 1'b1;
            end
            default: ;
        endcase
    end

    // killed instr still leaves fetch, but as a bubble
    assign dec_valid_o = instr_valid_i && !kill_i;

endmodule

//--- design/reg_file.sv
`timescale 1ns/1ps

module reg_file import riscv_isa_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [REG_IDX_W-1:0] rs1_idx_i,
    input  logic [REG_IDX_W-1:0] rs2_idx_i,
    output logic [XLEN-1:0]      rs1_val_o,
    output logic [XLEN-1:0]      rs2_val_o,
    input  logic                 we_i,
    input  logic [REG_IDX_W-1:0] wr_idx_i,
    input  logic [XLEN-1:0]      wr_data_i
);

    // x0 has no storage
    logic [XLEN-1:0] regs [1:31];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && wr_idx_i != '0) begin
            regs[wr_idx_i] <= wr_data_i;
        end
    end

    assign rs1_val_o = (rs1_idx_i == '0) ? '0 : regs[rs1_idx_i];
    assign rs2_val_o = (rs2_idx_i == '0) ? '0 : regs[rs2_idx_i];

endmodule

//--- design/pipe_stage.sv
`timescale 1ns/1ps

module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     valid_i,
    output logic     ready_o,
    input  payload_t data_i,
    output logic     valid_o,
    input  logic     ready_i,
    output payload_t data_o
);

    // accept when empty or when the entry leaves this cycle
    assign ready_o = !valid_o || ready_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_o <= 1'b0;
        end else if (ready_o) begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (ready_o) begin
            data_o <= data_i;
        end
    end

endmodule

//--- design/ex_stage.sv
`timescale 1ns/1ps

module ex_stage import riscv_isa_pkg::*, pipe_pkg::*; (
    input  logic                 ex_valid_i,
    input  id_ex_t               ex_i,
    input  logic                 fwd_valid_i,
    input  ex_res_t              fwd_i,
    input  logic                 adv_i,
    output ex_res_t              res_o,
    output logic                 we_o,
    output logic [REG_IDX_W-1:0] wr_idx_o,
    output logic [XLEN-1:0]      wr_data_o,
    output logic                 redirect_valid_o,
    output logic [XLEN-1:0]      redirect_pc_o
);

    logic            fwd_hit;
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
    logic [XLEN-1:0] src1;
    logic [XLEN-1:0] src2;
    logic [XLEN-1:0] alu_res;
    logic [XLEN-1:0] jalr_sum;
    logic            cond;
    logic            taken;

    // older result that decode read too early
    assign fwd_hit = fwd_valid_i && fwd_i.wben && fwd_i.rd != '0;
    assign rs1 = (fwd_hit && fwd_i.rd == ex_i.rs1_idx) ? fwd_i.data : ex_i.rs1_val;
    assign rs2 = (fwd_hit && fwd_i.rd == ex_i.rs2_idx) ? fwd_i.data : ex_i.rs2_val;

    assign src1 = (ex_i.src1_sel == SRC1_PC) ? ex_i.pc : rs1;
    assign src2 = (ex_i.src2_sel == SRC2_IMM) ? ex_i.imm : rs2;

    always_comb begin
        unique case (ex_i.alu_op)
            ADD:     alu_res = src1 + src2;
            SUB:     alu_res = src1 - src2;
            SLL:     alu_res = src1 << src2[4:0];
            SLT:     alu_res = {31'b0, $signed(src1) < $signed(src2)};
            SLTU:    alu_res = {31'b0, src1 < src2};
            XOR:     alu_res = src1 ^ src2;
            SRL:     alu_res = src1 >> src2[4:0];
            SRA:     alu_res = $unsigned($signed(src1) >>> src2[4:0]);
            OR:      alu_res = src1 | src2;
            AND:     alu_res = src1 & src2;
            default: alu_res = src2;
        endcase
    end

    always_comb begin
        unique case (ex_i.funct3)
            F3_BEQ:  cond = rs1 == rs2;
            F3_BNE:  cond = rs1 != rs2;
            F3_BLT:  cond = $signed(rs1) < $signed(rs2);
            F3_BGE:  cond = $signed(rs1) >= $signed(rs2);
            F3_BLTU: cond = rs1 < rs2;
            F3_BGEU: cond = rs1 >= rs2;
            default: cond = 1'b0;
        endcase
    end

    assign taken    = (ex_i.is_branch && cond) || ex_i.is_jal || ex_i.is_jalr;
    assign jalr_sum = rs1 + ex_i.imm;

    assign redirect_pc_o = ex_i.is_jalr ? {jalr_sum[XLEN-1:1], 1'b0} : ex_i.pc + ex_i.imm;

    // only when leaving EX, so a held instr redirects once
    assign redirect_valid_o = ex_valid_i && adv_i && taken;

    // jumps link pc + 4
    assign res_o.pc   = ex_i.pc;
    assign res_o.rd   = ex_i.rd;
    assign res_o.wben = ex_i.wben;
    assign res_o.data = (ex_i.is_jal || ex_i.is_jalr) ? ex_i.pc + 32'd4 : alu_res;

    assign we_o      = ex_valid_i && adv_i && ex_i.wben && ex_i.rd != '0;
    assign wr_idx_o  = ex_i.rd;
    assign wr_data_o = res_o.data;

endmodule

//--- design/exec_core.sv
`timescale 1ns/1ps

module exec_core import riscv_isa_pkg::*, pipe_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 instr_valid_i,
    input  logic [31:0]          instr_i,
    input  logic [XLEN-1:0]      instr_pc_i,
    output logic                 instr_ready_o,
    output logic                 res_valid_o,
    output logic [XLEN-1:0]      res_pc_o,
    output logic [REG_IDX_W-1:0] res_rd_o,
    output logic [XLEN-1:0]      res_data_o,
    output logic                 res_wben_o,
    input  logic                 res_ready_i,
    output logic                 redirect_valid_o,
    output logic [XLEN-1:0]      redirect_pc_o
);

    logic [REG_IDX_W-1:0] rs1_idx;
    logic [REG_IDX_W-1:0] rs2_idx;
    logic [XLEN-1:0]      rs1_val;
    logic [XLEN-1:0]      rs2_val;
    logic                 dec_valid;
    id_ex_t               dec;
    logic                 ex_valid;
    id_ex_t               ex;
    logic                 res_ready;
    ex_res_t              ex_res;
    ex_res_t              res;
    logic                 we;
    logic [REG_IDX_W-1:0] wr_idx;
    logic [XLEN-1:0]      wr_data;

    id_stage u_id_stage (
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .instr_pc_i    (instr_pc_i),
        .kill_i        (redirect_valid_o),
        .rs1_idx_o     (rs1_idx),
        .rs2_idx_o     (rs2_idx),
        .rs1_val_i     (rs1_val),
        .rs2_val_i     (rs2_val),
        .dec_valid_o   (dec_valid),
        .dec_o         (dec)
    );

    reg_file u_reg_file (
        .clk       (clk),
        .rst_n     (rst_n),
        .rs1_idx_i (rs1_idx),
        .rs2_idx_i (rs2_idx),
        .rs1_val_o (rs1_val),
        .rs2_val_o (rs2_val),
        .we_i      (we),
        .wr_idx_i  (wr_idx),
        .wr_data_i (wr_data)
    );

    pipe_stage #(.payload_t(id_ex_t)) id_ex_stage (
        .clk     (clk),
        .rst_n   (rst_n),
        .valid_i (dec_valid),
        .ready_o (instr_ready_o),
        .data_i  (dec),
        .valid_o (ex_valid),
        .ready_i (res_ready),
        .data_o  (ex)
    );

    ex_stage u_ex_stage (
        .ex_valid_i       (ex_valid),
        .ex_i             (ex),
        .fwd_valid_i      (res_valid_o),
        .fwd_i            (res),
        .adv_i            (res_ready),
        .res_o            (ex_res),
        .we_o             (we),
        .wr_idx_o         (wr_idx),
        .wr_data_o        (wr_data),
        .redirect_valid_o (redirect_valid_o),
        .redirect_pc_o    (redirect_pc_o)
    );

    pipe_stage #(.payload_t(ex_res_t)) result_stage (
        .clk     (clk),
        .rst_n   (rst_n),
        .valid_i (ex_valid),
        .ready_o (res_ready),
        .data_i  (ex_res),
        .valid_o (res_valid_o),
        .ready_i (res_ready_i),
        .data_o  (res)
    );

    assign res_pc_o   = res.pc;
    assign res_rd_o   = res.rd;
    assign res_data_o = res.data;
    assign res_wben_o = res.wben;

endmodule

//--- tb/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter real PERIOD = 100.0
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    always #(PERIOD / 2.0) clk_o = ~clk_o;

endmodule

//--- tb/exec_core_asserts.sv
`timescale 1ns/1ps

module exec_core_asserts (
    input logic        clk,
    input logic        rst_n,
    input logic        res_valid_o,
    input logic        res_ready_i,
    input logic [31:0] res_pc_o,
    input logic [4:0]  res_rd_o,
    input logic [31:0] res_data_o,
    input logic        res_wben_o,
    input logic        redirect_valid_o
);

    // held result must not change until taken
    assert property (@(posedge clk) disable iff (!rst_n)
        res_valid_o && !res_ready_i |=> res_valid_o && $stable(res_pc_o)
            && $stable(res_rd_o) && $stable(res_data_o) && $stable(res_wben_o))
        else $error("result changed while held");

    assert property (@(posedge clk) disable iff (!rst_n)
        redirect_valid_o |=> !redirect_valid_o)
        else $error("redirect longer than one cycle");

    // valids come out of reset low
    assert property (@(posedge clk) $rose(rst_n) |-> !res_valid_o && !redirect_valid_o)
        else $error("valid outputs high after reset");

endmodule

//--- tb/exec_core_tb.sv
`timescale 1ns/1ps

module exec_core_tb import riscv_isa_pkg::*; ();

    localparam int TIMEOUT = 200;

    logic clk, rst_n, instr_valid_i, res_ready_i, res_valid_o, res_wben_o;
    logic instr_ready_o, redirect_valid_o;
    logic [31:0] instr_i, instr_pc_i, res_pc_o, res_data_o, redirect_pc_o;
    logic [4:0]  res_rd_o;

    // stimulus table
    int          n_entries;
    logic [31:0] t_instr [32];
    logic [31:0] t_pc [32];
    bit          t_kill [32];
    logic [4:0]  t_rd [32];
    logic [31:0] t_data [32];
    bit          t_wben [32];
    bit          t_redir [32];
    logic [31:0] t_redir_pc [32];

    logic [31:0] got_pc [$];
    logic [31:0] got_data [$];
    logic [4:0]  got_rd [$];
    bit          got_wben [$];
    logic [31:0] got_redir [$];
    int          errors;
    int          tests;

    tb_clock u_clock (.clk_o(clk));

    exec_core uut (.*);

    bind exec_core exec_core_asserts u_asserts (.*);

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    task automatic add_entry(input logic [31:0] instr, input logic [31:0] pc, input bit kill,
                             input logic [4:0] rd, input logic [31:0] data, input bit wben,
                             input bit redir, input logic [31:0] redir_pc);
        t_instr[n_entries]    = instr;
        t_pc[n_entries]       = pc;
        t_kill[n_entries]     = kill;
        t_rd[n_entries]       = rd;
        t_data[n_entries]     = data;
        t_wben[n_entries]     = wben;
        t_redir[n_entries]    = redir;
        t_redir_pc[n_entries] = redir_pc;
        n_entries++;
    endtask

    task automatic build_table();
        add_entry(enc_i(12'd5, 0, F3_ADD, 1, OPC_OP_IMM), 32'h100, 0, 1, 32'd5, 1, 0, 0);
        add_entry(enc_i(12'hffd, 0, F3_ADD, 2, OPC_OP_IMM), 32'h104, 0, 2, 32'hfffffffd, 1, 0, 0);
        add_entry({20'h12345, 5'd3, OPC_LUI}, 32'h108, 0, 3, 32'h12345000, 1, 0, 0);
        add_entry({20'h00001, 5'd4, OPC_AUIPC}, 32'h10c, 0, 4, 32'h0000110c, 1, 0, 0);
        // dependent chain of register ops
        add_entry(enc_r(7'h00, 2, 1, F3_ADD, 5), 32'h110, 0, 5, 32'd2, 1, 0, 0);
        add_entry(enc_r(7'h20, 1, 5, F3_ADD, 6), 32'h114, 0, 6, 32'hfffffffd, 1, 0, 0);
        add_entry(enc_r(7'h00, 1, 6, F3_SLT, 7), 32'h118, 0, 7, 32'd1, 1, 0, 0);
        add_entry(enc_r(7'h00, 1, 6, F3_SLTU, 8), 32'h11c, 0, 8, 32'd0, 1, 0, 0);
        add_entry(enc_r(7'h00, 7, 1, F3_SLL, 9), 32'h120, 0, 9, 32'd10, 1, 0, 0);
        add_entry(enc_r(7'h20, 7, 6, F3_SR, 10), 32'h124, 0, 10, 32'hfffffffe, 1, 0, 0);
        add_entry(enc_r(7'h00, 7, 10, F3_SR, 11), 32'h128, 0, 11, 32'h7fffffff, 1, 0, 0);
        add_entry(enc_r(7'h00, 9, 11, F3_XOR, 12), 32'h12c, 0, 12, 32'h7ffffff5, 1, 0, 0);
        add_entry(enc_r(7'h00, 1, 12, F3_OR, 13), 32'h130, 0, 13, 32'h7ffffff5, 1, 0, 0);
        add_entry(enc_r(7'h00, 1, 13, F3_AND, 14), 32'h134, 0, 14, 32'd5, 1, 0, 0);
        // flow control
        add_entry(enc_b(13'd16, 1, 14, F3_BEQ), 32'h138, 0, 0, 0, 0, 1, 32'h148);
        add_entry(enc_i(12'd99, 0, F3_ADD, 15, OPC_OP_IMM), 32'h13c, 1, 0, 0, 0, 0, 0);
        add_entry(enc_b(13'd8, 1, 1, F3_BNE), 32'h148, 0, 0, 0, 0, 0, 0);
        add_entry(enc_i(12'd7, 0, F3_ADD, 16, OPC_OP_IMM), 32'h14c, 0, 16, 32'd7, 1, 0, 0);
        add_entry(enc_b(13'h1ff8, 1, 2, F3_BLT), 32'h150, 0, 0, 0, 0, 1, 32'h148);
        add_entry(enc_i(12'd1, 0, F3_ADD, 17, OPC_OP_IMM), 32'h154, 1, 0, 0, 0, 0, 0);
        add_entry(enc_j(21'd32, 18), 32'h200, 0, 18, 32'h204, 1, 1, 32'h220);
        add_entry(enc_i(12'd1, 0, F3_ADD, 19, OPC_OP_IMM), 32'h204, 1, 0, 0, 0, 0, 0);
        // x9 + 7 is 17 and bit 0 is cleared
        add_entry(enc_i(12'd7, 9, 3'b000, 20, OPC_JALR), 32'h220, 0, 20, 32'h224, 1, 1, 32'h10);
        add_entry(enc_r(7'h00, 1, 1, F3_ADD, 21), 32'h224, 1, 0, 0, 0, 0, 0);
        add_entry(enc_i(12'd100, 1, F3_ADD, 0, OPC_OP_IMM), 32'h010, 0, 0, 32'd105, 1, 0, 0);
        add_entry(enc_r(7'h00, 1, 0, F3_ADD, 22), 32'h014, 0, 22, 32'd5, 1, 0, 0);
        add_entry(enc_i(12'd1, 22, F3_ADD, 23, OPC_OP_IMM), 32'h018, 0, 23, 32'd6, 1, 0, 0);
        add_entry(enc_r(7'h00, 20, 18, F3_ADD, 24), 32'h01c, 0, 24, 32'h428, 1, 0, 0);
    endtask

    // sampled before the edge updates any register
    always @(posedge clk) begin
        if (rst_n && res_valid_o && res_ready_i) begin
            got_pc.push_back(res_pc_o);
            got_data.push_back(res_data_o);
            got_rd.push_back(res_rd_o);
            got_wben.push_back(res_wben_o);
        end
        if (rst_n && redirect_valid_o) begin
            got_redir.push_back(redirect_pc_o);
        end
    end

    task automatic drive_all();
        int  cycles;
        bit  accepted;
        bit  killed;
        for (int i = 0; i < n_entries; i++) begin
            @(negedge clk);
            instr_valid_i = 1'b1;
            instr_i       = t_instr[i];
            instr_pc_i    = t_pc[i];
            accepted = 0;
            cycles   = 0;
            while (!accepted && cycles < TIMEOUT) begin
                @(posedge clk);
                accepted = instr_ready_o;
                killed   = redirect_valid_o;
                cycles++;
            end
            if (!accepted) begin
                $display("timeout: fetch handshake never completed for entry %0d", i);
                errors++;
                break;
            end
            assert (killed == t_kill[i]) else begin
                $display("[ERROR] %0t: entry %0d kill %0b, expected %0b", $time, i, killed,
                         t_kill[i]);
                errors++;
            end
            if (t_kill[i]) begin
                tests++;
                $display("test %0d pc %h: %s", i, t_pc[i], killed ? "killed" : "mismatch");
            end
        end
        @(negedge clk);
        instr_valid_i = 1'b0;
    endtask

    task automatic check_all();
        int          cycles;
        int          bad;
        logic [31:0] pc;
        logic [31:0] data;
        logic [4:0]  rd;
        bit          wben;
        for (int i = 0; i < n_entries; i++) begin
            if (t_kill[i]) begin
                continue;
            end
            cycles = 0;
            while (got_pc.size() == 0 && cycles < TIMEOUT) begin
                @(posedge clk);
                cycles++;
            end
            if (got_pc.size() == 0) begin
                $display("timeout: no result arrived for entry %0d", i);
                errors++;
                return;
            end
            pc   = got_pc.pop_front();
            data = got_data.pop_front();
            rd   = got_rd.pop_front();
            wben = got_wben.pop_front();
            bad  = errors;
            assert (pc == t_pc[i] && wben == t_wben[i]) else begin
                $display("[ERROR] %0t: entry %0d pc %h wben %0b, expected pc %h wben %0b",
                         $time, i, pc, wben, t_pc[i], t_wben[i]);
                errors++;
            end
            assert (!t_wben[i] || (rd == t_rd[i] && data == t_data[i])) else begin
                $display("[ERROR] %0t: entry %0d rd %0d data %h, expected rd %0d data %h",
                         $time, i, rd, data, t_rd[i], t_data[i]);
                errors++;
            end
            tests++;
            $display("test %0d pc %h: %s", i, t_pc[i], (errors == bad) ? "ok" : "mismatch");
        end
    endtask

    task automatic check_redirects();
        logic [31:0] pc;
        int          n_exp;
        n_exp = 0;
        for (int i = 0; i < n_entries; i++) begin
            if (t_redir[i]) begin
                n_exp++;
                if (got_redir.size() == 0) begin
                    $display("missing redirect for entry %0d", i);
                    errors++;
                    continue;
                end
                pc = got_redir.pop_front();
                assert (pc == t_redir_pc[i]) else begin
                    $display("[ERROR] %0t: entry %0d redirect %h, expected %h", $time, i, pc,
                             t_redir_pc[i]);
                    errors++;
                end
            end
        end
        assert (got_redir.size() == 0 && got_pc.size() == 0) else begin
            $display("[ERROR] %0t: %0d extra redirects, %0d extra results", $time,
                     got_redir.size(), got_pc.size());
            errors++;
        end
        $display("redirects expected %0d", n_exp);
    endtask

    initial begin
        void'($urandom(42));
        rst_n         = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        instr_pc_i    = '0;
        res_ready_i   = 1'b0;
        errors        = 0;
        tests         = 0;
        n_entries     = 0;
        build_table();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        fork
            forever begin
                @(negedge clk);
                res_ready_i = ($urandom % 4) != 0;
            end
        join_none
        fork
            drive_all();
            check_all();
        join
        // let any stray result or redirect show up
        repeat (20) @(posedge clk);
        check_redirects();
        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- exec_core.f
design/riscv_isa_pkg.sv
design/pipe_pkg.sv
design/id_stage.sv
design/reg_file.sv
design/pipe_stage.sv
design/ex_stage.sv
design/exec_core.sv
tb/tb_clock.sv
tb/exec_core_asserts.sv
tb/exec_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= exec_core_tb
FILELIST  ?= exec_core.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= All tests passed!

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
